//--- Makefile
# Verilator flow for the peripheral subsystem

VERILATOR ?= verilator
TOP       ?= periph_soc_tb
RTL_TOP   ?= periph_soc
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		design/soc_map_pkg.sv design/soc_bus_pkg.sv design/bus_ctrl_fsm.sv \
		design/mtimer.sv design/gpio_regs.sv design/irq_ctrl.sv design/periph_soc.sv
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- design/bus_ctrl_fsm.sv
/*
  Bus controller between the external req/ack master and the three
  peripherals. Serves the four-phase handshake, decodes the region of
  the latched request, strobes the selected peripheral for one cycle
  and registers the response. Unmapped regions answer with err set.
*/
`timescale 1ns/1ns

module bus_ctrl_fsm import soc_map_pkg::*, soc_bus_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_req,
  input  bus_req_t              i_bus,
  input  logic [DATA_W-1:0]     i_gpio_rdata,
  input  logic [DATA_W-1:0]     i_tmr_rdata,
  input  logic [DATA_W-1:0]     i_irq_rdata,
  output logic                  o_ack,
  output bus_rsp_t              o_rsp,
  output periph_acc_t           o_acc,
  output logic [NUM_SLAVES-1:0] o_sel
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_DONE
  } state_t;

  state_t                state_q;
  bus_req_t              req_q;
  logic [3:0]            region;
  logic [NUM_SLAVES-1:0] sel_dec;
  logic                  mapped;
  logic                  in_access;
  logic [DATA_W-1:0]     rdata_mux;

  ////////////////////////////////////////
  // region decode of the latched request
  assign region = req_q.addr[ADDR_W-1 -: 4];

  always_comb begin
    sel_dec   = '0;
    rdata_mux = '0;
    case (region)
      REGION_GPIO: begin
        sel_dec[SLV_GPIO] = 1'b1;
        rdata_mux         = i_gpio_rdata;
      end
      REGION_TIMER: begin
        sel_dec[SLV_TIMER] = 1'b1;
        rdata_mux          = i_tmr_rdata;
      end
      REGION_IRQ: begin
        sel_dec[SLV_IRQ] = 1'b1;
        rdata_mux        = i_irq_rdata;
      end
      // unmapped, nobody is selected and data reads as zero
      default: begin
        sel_dec   = '0;
        rdata_mux = '0;
      end
    endcase
  end

  assign mapped    = |sel_dec;
  assign in_access = (state_q == ST_ACCESS);

  // strobes live only during the single ACCESS cycle
  assign o_sel       = in_access ? sel_dec : '0;
  assign o_acc.wr    = in_access & mapped & req_q.we;
  assign o_acc.rd    = in_access & mapped & ~req_q.we;
  assign o_acc.idx   = req_q.addr[5:2];
  assign o_acc.wdata = req_q.wdata;

  ////////////////////////////////////////
  // handshake FSM
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      o_ack   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            state_q <= ST_ACCESS;
          end
        end
        // response is captured at the end of this cycle
        ST_ACCESS: begin
          state_q <= ST_DONE;
        end
        // ack rises one edge into DONE and stays until req drops
        ST_DONE: begin
          if (!i_req) begin
            state_q <= ST_IDLE;
            o_ack   <= 1'b0;
          end else begin
            o_ack <= 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
          o_ack   <= 1'b0;
        end
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_req) begin
      req_q <= i_bus;
    end
    if (in_access) begin
      o_rsp.rdata <= rdata_mux;
      o_rsp.err   <= ~mapped;
    end
  end

endmodule

//--- design/gpio_regs.sv
/*
  GPIO block. Holds output and direction registers, brings the pins
  in through a two-flop synchronizer and latches a pending bit on
  each rising edge. Pending clears by writing ones; o_irq is raised
  while any pending pin is also enabled.
*/
`timescale 1ns/1ns

module gpio_regs import soc_map_pkg::*, soc_bus_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_sel,
  input  periph_acc_t           i_acc,
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [DATA_W-1:0]     o_rdata,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                  o_irq
);

  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;
  logic [GPIO_WIDTH-1:0] pend_q;
  logic [GPIO_WIDTH-1:0] en_q;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] clr;
  logic                  wr_en;

  assign wr_en = i_sel & i_acc.wr;

  // edge seen between the synced value and its previous sample
  assign rise = sync2_q & ~prev_q;

  // write-one-to-clear mask
  assign clr = (wr_en && i_acc.idx == GPIO_IRQ_PEND) ? i_acc.wdata[GPIO_WIDTH-1:0] : '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_q   <= '0;
      dir_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      pend_q  <= '0;
      en_q    <= '0;
    end else begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // a new edge wins over a clear in the same cycle
      pend_q  <= (pend_q & ~clr) | rise;
      if (wr_en && i_acc.idx == GPIO_OUT) begin
        out_q <= i_acc.wdata[GPIO_WIDTH-1:0];
      end
      if (wr_en && i_acc.idx == GPIO_DIR) begin
        dir_q <= i_acc.wdata[GPIO_WIDTH-1:0];
      end
      if (wr_en && i_acc.idx == GPIO_IRQ_EN) begin
        en_q <= i_acc.wdata[GPIO_WIDTH-1:0];
      end
    end
  end

  // read port
  always_comb begin
    case (i_acc.idx)
      GPIO_OUT:      o_rdata = DATA_W'(out_q);
      GPIO_DIR:      o_rdata = DATA_W'(dir_q);
      GPIO_IN:       o_rdata = DATA_W'(sync2_q);
      GPIO_IRQ_PEND: o_rdata = DATA_W'(pend_q);
      GPIO_IRQ_EN:   o_rdata = DATA_W'(en_q);
      default:       o_rdata = '0;
    endcase
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = |(pend_q & en_q);

endmodule

//--- design/irq_ctrl.sv
/*
  Small platform interrupt controller. Level sources are latched into
  pending bits (bit n holds id n+1). A CLAIM read returns the lowest
  enabled pending id, or 0 when there is none, and clears that bit.
*/
`timescale 1ns/1ns

module irq_ctrl import soc_map_pkg::*, soc_bus_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_sel,
  input  periph_acc_t        i_acc,
  input  logic [IRQ_NUM-1:0] i_src,
  output logic [DATA_W-1:0]  o_rdata,
  output logic               o_ext_irq
);

  logic [IRQ_NUM-1:0]  pend_q;
  logic [IRQ_NUM-1:0]  en_q;
  logic [IRQ_NUM-1:0]  active;
  logic [IRQ_NUM-1:0]  clr;
  logic [IRQ_ID_W-1:0] claim_id;
  logic                claim_rd;

  assign active   = pend_q & en_q;
  assign claim_rd = i_sel & i_acc.rd & (i_acc.idx == IRQ_CLAIM);

  ////////////////////////////////////////
  // lowest id wins, scan from the top down
  always_comb begin
    claim_id = '0;
    for (int i = IRQ_NUM - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id = IRQ_ID_W'(i + 1);
      end
    end
  end

  // claimed bit goes away at the strobe edge
  always_comb begin
    clr = '0;
    for (int i = 0; i < IRQ_NUM; i++) begin
      clr[i] = claim_rd && (claim_id == IRQ_ID_W'(i + 1));
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      // the claim clears first, a source still high re-pends next cycle
      pend_q <= (pend_q | i_src) & ~clr;
      if (i_sel && i_acc.wr && i_acc.idx == IRQ_ENABLE) begin
        en_q <= i_acc.wdata[IRQ_NUM-1:0];
      end
    end
  end

  // read port, claim id reflects the state before the clear
  always_comb begin
    case (i_acc.idx)
      IRQ_PENDING: o_rdata = DATA_W'(pend_q);
      IRQ_ENABLE:  o_rdata = DATA_W'(en_q);
      IRQ_CLAIM:   o_rdata = DATA_W'(claim_id);
      default:     o_rdata = '0;
    endcase
  end

  assign o_ext_irq = |active;

endmodule

//--- design/mtimer.sv
/*
  Machine timer. A prescaler of TIMER_DIV clocks advances mtime while
  the enable bit in TMR_CTRL is set. o_mtip flags mtime >= mtimecmp.
  All registers are reached through the controller access strobes.
*/
`timescale 1ns/1ns

module mtimer import soc_map_pkg::*, soc_bus_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_sel,
  input  periph_acc_t       i_acc,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_mtip
);

  logic [TIMER_PRESC_W-1:0] presc_q;
  logic [DATA_W-1:0]        mtime_q;
  logic [DATA_W-1:0]        mtimecmp_q;
  logic                     en_q;
  logic                     wr_en;
  logic                     tick;

  assign wr_en = i_sel & i_acc.wr;

  // last prescaler count of an enabled timer
  assign tick = en_q & (presc_q == TIMER_PRESC_W'(TIMER_DIV - 1));

  ////////////////////////////////////////
  // counter and registers
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      presc_q    <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      en_q       <= 1'b0;
    end else begin
      // a software write of mtime also restarts the prescaler
      if (wr_en && i_acc.idx == TMR_MTIME) begin
        mtime_q <= i_acc.wdata;
        presc_q <= '0;
      end else if (en_q) begin
        presc_q <= tick ? '0 : presc_q + 1'b1;
        if (tick) begin
          mtime_q <= mtime_q + 1'b1;
        end
      end
      if (wr_en && i_acc.idx == TMR_MTIMECMP) begin
        mtimecmp_q <= i_acc.wdata;
      end
      if (wr_en && i_acc.idx == TMR_CTRL) begin
        en_q <= i_acc.wdata[0];
      end
    end
  end

  // read port, unknown indices read zero
  always_comb begin
    case (i_acc.idx)
      TMR_MTIME:    o_rdata = mtime_q;
      TMR_MTIMECMP: o_rdata = mtimecmp_q;
      TMR_CTRL:     o_rdata = DATA_W'(en_q);
      default:      o_rdata = '0;
    endcase
  end

  // compare interrupt, masked while the timer is stopped
  assign o_mtip = en_q & (mtime_q >= mtimecmp_q);

endmodule

//--- design/periph_soc.sv
/*
  Top level of the peripheral subsystem. The external master talks to
  the bus controller, which fans out to GPIO, machine timer and the
  interrupt controller. GPIO and timer interrupts feed the controller.
*/
`timescale 1ns/1ns

module periph_soc import soc_map_pkg::*, soc_bus_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // external master port
  input  logic                  i_req,
  input  bus_req_t              i_bus,
  output logic                  o_ack,
  output bus_rsp_t              o_rsp,
  // pins
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_dir,
  // interrupt lines
  output logic                  o_mtip,
  output logic                  o_ext_irq
);

  periph_acc_t           acc;
  logic [NUM_SLAVES-1:0] sel;
  logic [DATA_W-1:0]     gpio_rdata;
  logic [DATA_W-1:0]     tmr_rdata;
  logic [DATA_W-1:0]     irq_rdata;
  logic                  gpio_irq;
  logic [IRQ_NUM-1:0]    irq_src;

  // source vector is indexed by id minus one
  assign irq_src[IRQ_ID_GPIO-1]  = gpio_irq;
  assign irq_src[IRQ_ID_TIMER-1] = o_mtip;

  ////////////////////////////////////////
  // bus controller
  bus_ctrl_fsm ctrl0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_bus        (i_bus),
    .i_gpio_rdata (gpio_rdata),
    .i_tmr_rdata  (tmr_rdata),
    .i_irq_rdata  (irq_rdata),
    .o_ack        (o_ack),
    .o_rsp        (o_rsp),
    .o_acc        (acc),
    .o_sel        (sel)
  );

  ////////////////////////////////////////
  // peripherals
  gpio_regs gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_sel      (sel[SLV_GPIO]),
    .i_acc      (acc),
    .i_gpio     (i_gpio),
    .o_rdata    (gpio_rdata),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq      (gpio_irq)
  );

  mtimer tmr0 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_sel   (sel[SLV_TIMER]),
    .i_acc   (acc),
    .o_rdata (tmr_rdata),
    .o_mtip  (o_mtip)
  );

  irq_ctrl irqc0 (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_sel     (sel[SLV_IRQ]),
    .i_acc     (acc),
    .i_src     (irq_src),
    .o_rdata   (irq_rdata),
    .o_ext_irq (o_ext_irq)
  );

endmodule

//--- design/soc_bus_pkg.sv
/*
  Bundles that travel on the external master port and on the
  internal peripheral access path. The external master drives
  bus_req_t and gets bus_rsp_t back; the controller broadcasts
  periph_acc_t to all peripherals.
*/
package soc_bus_pkg;

  import soc_map_pkg::*;

  // request held stable by the master while i_req is high
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // response, valid while o_ack is high
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // one-cycle access strobes, qualified by the select bit
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [3:0]        idx;
    logic [DATA_W-1:0] wdata;
  } periph_acc_t;

endpackage

//--- design/soc_map_pkg.sv
/*
  Address map and register layout of the peripheral subsystem.
  Imported by the bus controller, every peripheral and the testbench
  so that region codes, register indices and sizes stay in one place.
*/
package soc_map_pkg;

  ////////////////////////////////////////
  // bus geometry
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // region code sits in addr[15:12], register index in addr[5:2]
  localparam logic [3:0] REGION_GPIO  = 4'd1;
  localparam logic [3:0] REGION_TIMER = 4'd2;
  localparam logic [3:0] REGION_IRQ   = 4'd3;

  // one select bit per peripheral
  localparam int NUM_SLAVES = 3;
  localparam int SLV_GPIO   = 0;
  localparam int SLV_TIMER  = 1;
  localparam int SLV_IRQ    = 2;

  ////////////////////////////////////////
  // register indices
  localparam logic [3:0] GPIO_OUT      = 4'd0;
  localparam logic [3:0] GPIO_DIR      = 4'd1;
  localparam logic [3:0] GPIO_IN       = 4'd2;
  localparam logic [3:0] GPIO_IRQ_PEND = 4'd3;
  localparam logic [3:0] GPIO_IRQ_EN   = 4'd4;

  localparam logic [3:0] TMR_MTIME    = 4'd0;
  localparam logic [3:0] TMR_MTIMECMP = 4'd1;
  localparam logic [3:0] TMR_CTRL     = 4'd2;

  localparam logic [3:0] IRQ_PENDING = 4'd0;
  localparam logic [3:0] IRQ_ENABLE  = 4'd1;
  localparam logic [3:0] IRQ_CLAIM   = 4'd2;

  ////////////////////////////////////////
  // peripheral sizes
  localparam int GPIO_WIDTH    = 8;
  localparam int TIMER_DIV     = 4;
  localparam int TIMER_PRESC_W = $clog2(TIMER_DIV);

  // interrupt ids, 0 is reserved for "nothing pending"
  localparam int IRQ_NUM      = 2;
  localparam int IRQ_ID_W     = 2;
  localparam int IRQ_ID_GPIO  = 1;
  localparam int IRQ_ID_TIMER = 2;

endpackage

//--- filelist.f
design/soc_map_pkg.sv
design/soc_bus_pkg.sv
design/bus_ctrl_fsm.sv
design/mtimer.sv
design/gpio_regs.sv
design/irq_ctrl.sv
design/periph_soc.sv
verification/periph_soc_properties.sv
verification/periph_soc_tb.sv

//--- verification/periph_soc_properties.sv
/*
  Handshake and strobe properties of the bus controller. Bound to
  every bus_ctrl_fsm instance; failures show up as assertion errors.
*/
`timescale 1ns/1ns

module periph_soc_properties import soc_map_pkg::*, soc_bus_pkg::*; (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_req,
  input logic                  o_ack,
  input logic [NUM_SLAVES-1:0] o_sel,
  input periph_acc_t           o_acc
);

  // ack only ever rises in answer to a live request
  // req was sampled at the edge that set ack
  ack_rise_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_ack) |-> $past(i_req)) else $error("ack rose without req");

  // ack held while the master keeps req up
  ack_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ack && i_req) |=> o_ack) else $error("ack dropped under req");

  // at most one peripheral selected
  sel_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_sel)) else $error("more than one select bit");

  // single-cycle strobes
  strobe_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_acc.wr || o_acc.rd) |=> !(o_acc.wr || o_acc.rd)) else $error("strobe too long");

endmodule

bind bus_ctrl_fsm periph_soc_properties u_props (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_req   (i_req),
  .o_ack   (o_ack),
  .o_sel   (o_sel),
  .o_acc   (o_acc)
);

//--- verification/periph_soc_tb.sv
/*
  Testbench for the peripheral subsystem. Drives the req/ack master
  port on the falling edge, keeps a register model, and checks every
  read against a reference function in a separate comparing process.
  Covers GPIO, timer, interrupt claim, unmapped access and long holds.
*/
`timescale 1ns/1ns

module periph_soc_tb import soc_map_pkg::*, soc_bus_pkg::*; ();

  typedef struct {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] exp_data;
    logic              exp_err;
    logic [DATA_W-1:0] got_data;
    logic              got_err;
    logic              chk_data;
  } chk_t;

  localparam int WAIT_LIMIT = 100;

  logic i_clk = 1'b0;
  logic i_rst_n;
  logic i_req;
  bus_req_t i_bus;
  logic [GPIO_WIDTH-1:0] i_gpio;
  logic o_ack;
  bus_rsp_t o_rsp;
  logic [GPIO_WIDTH-1:0] o_gpio;
  logic [GPIO_WIDTH-1:0] o_gpio_dir;
  logic o_mtip;
  logic o_ext_irq;

  // register model
  logic [GPIO_WIDTH-1:0] m_gpio_out, m_gpio_dir, m_gpio_en, m_gpio_in, m_gpio_pend;
  logic [DATA_W-1:0] m_tmr_cmp;
  logic m_tmr_en;
  logic [IRQ_NUM-1:0] m_irq_en, m_irq_pend;

  chk_t chk_q[$];
  event rsp_ev;
  int strobe_cnt = 0;
  logic [DATA_W-1:0] last_rdata;
  logic [GPIO_WIDTH-1:0] pat;
  logic [DATA_W-1:0] t0, cmp;
  int n;

  always #2 i_clk = ~i_clk;

  periph_soc i_dut (.*);

  // count peripheral strobes to catch a repeated access
  always @(posedge i_clk) begin
    if (|i_dut.sel) begin
      strobe_cnt <= strobe_cnt + 1;
    end
  end

  task automatic fail_stop();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    fail_stop();
  endtask

  function automatic logic [ADDR_W-1:0] addr_of(input logic [3:0] rg, input logic [3:0] idx);
    return {rg, 6'b0, idx, 2'b00};
  endfunction

  // lowest enabled pending id of the model, 0 when none
  function automatic int model_claim_id();
    for (int i = 0; i < IRQ_NUM; i++) begin
      if (m_irq_pend[i] && m_irq_en[i]) return i + 1;
    end
    return 0;
  endfunction

  // expected {err, rdata} for a read of addr
  function automatic logic [DATA_W:0] ref_read(input logic [ADDR_W-1:0] addr);
    logic [3:0] rg;
    logic [3:0] idx;
    logic [DATA_W-1:0] d;
    rg  = addr[15:12];
    idx = addr[5:2];
    d   = '0;
    case (rg)
      REGION_GPIO: begin
        case (idx)
          GPIO_OUT:      d = DATA_W'(m_gpio_out);
          GPIO_DIR:      d = DATA_W'(m_gpio_dir);
          GPIO_IN:       d = DATA_W'(m_gpio_in);
          GPIO_IRQ_PEND: d = DATA_W'(m_gpio_pend);
          GPIO_IRQ_EN:   d = DATA_W'(m_gpio_en);
          default:       d = '0;
        endcase
      end
      REGION_TIMER: begin
        case (idx)
          TMR_MTIMECMP: d = m_tmr_cmp;
          TMR_CTRL:     d = DATA_W'(m_tmr_en);
          default:      d = '0;
        endcase
      end
      REGION_IRQ: begin
        case (idx)
          IRQ_PENDING: d = DATA_W'(m_irq_pend);
          IRQ_ENABLE:  d = DATA_W'(m_irq_en);
          IRQ_CLAIM:   d = DATA_W'(model_claim_id());
          default:     d = '0;
        endcase
      end
      default: return {1'b1, {DATA_W{1'b0}}};
    endcase
    return {1'b0, d};
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d);
    case ({addr[15:12], addr[5:2]})
      {REGION_GPIO, GPIO_OUT}:      m_gpio_out = d[GPIO_WIDTH-1:0];
      {REGION_GPIO, GPIO_DIR}:      m_gpio_dir = d[GPIO_WIDTH-1:0];
      {REGION_GPIO, GPIO_IRQ_EN}:   m_gpio_en = d[GPIO_WIDTH-1:0];
      {REGION_GPIO, GPIO_IRQ_PEND}: m_gpio_pend = m_gpio_pend & ~d[GPIO_WIDTH-1:0];
      {REGION_TIMER, TMR_MTIMECMP}: m_tmr_cmp = d;
      {REGION_TIMER, TMR_CTRL}:     m_tmr_en = d[0];
      {REGION_IRQ, IRQ_ENABLE}:     m_irq_en = d[IRQ_NUM-1:0];
      default: ;
    endcase
  endtask

  // one four-phase transfer, hold keeps req high for extra cycles
  task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wd, input bit chk, input int hold);
    logic [DATA_W:0] exp;
    chk_t c;
    int cnt0;
    int k;
    exp  = ref_read(addr);
    cnt0 = strobe_cnt;
    i_bus = '{we: we, addr: addr, wdata: wd};
    i_req = 1'b1;
    k = 0;
    do begin
      @(negedge i_clk);
      k++;
      if (k > WAIT_LIMIT) abort_on_timeout("ack high");
    end while (!o_ack);
    last_rdata = o_rsp.rdata;
    c = '{addr: addr, exp_data: exp[DATA_W-1:0], exp_err: exp[DATA_W],
          got_data: o_rsp.rdata, got_err: o_rsp.err, chk_data: chk && !we};
    chk_q.push_back(c);
    -> rsp_ev;
    // ack must stay up while the master holds req
    repeat (hold) begin
      @(negedge i_clk);
      assert (o_ack) else begin
        $display("Error: %0t ns ack dropped under held req at addr %h", $time, addr);
        fail_stop();
      end
    end
    i_req = 1'b0;
    k = 0;
    do begin
      @(negedge i_clk);
      k++;
      if (k > WAIT_LIMIT) abort_on_timeout("ack low");
    end while (o_ack);
    assert (strobe_cnt == cnt0 + (exp[DATA_W] ? 0 : 1)) else begin
      $display("Error: %0t ns wrong strobe count at addr %h", $time, addr);
      fail_stop();
    end
    if (we) model_write(addr, wd);
    else if (addr[15:12] == REGION_IRQ && addr[5:2] == IRQ_CLAIM && model_claim_id() != 0)
      m_irq_pend[model_claim_id() - 1] = 1'b0;
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      $display("Error: %0t ns %s is %b, expected %b", $time, what, got, exp);
      fail_stop();
    end
  endtask

  ////////////////////////////////////////
  // comparing process
  always @(rsp_ev) begin
    chk_t c;
    while (chk_q.size() > 0) begin
      c = chk_q.pop_front();
      assert (c.got_err === c.exp_err) else begin
        $display("Error: %0t ns addr %h err %b, expected %b", $time, c.addr, c.got_err,
                 c.exp_err);
        fail_stop();
      end
      assert (!c.chk_data || c.got_data === c.exp_data) else begin
        $display("Error: %0t ns addr %h rdata %h, expected %h", $time, c.addr, c.got_data,
                 c.exp_data);
        fail_stop();
      end
    end
  end

  initial begin
    void'($urandom(39007));
    i_rst_n = 1'b0;
    i_req = 1'b0;
    i_bus = '0;
    i_gpio = '0;
    {m_gpio_out, m_gpio_dir, m_gpio_en, m_gpio_in, m_gpio_pend} = '0;
    m_tmr_cmp = '1;
    m_tmr_en = 1'b0;
    m_irq_en = '0;
    m_irq_pend = '0;
    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);

    // gpio register read-back
    repeat (8) begin
      bus_xfer(1, addr_of(REGION_GPIO, GPIO_OUT), $urandom, 0, 0);
      bus_xfer(1, addr_of(REGION_GPIO, GPIO_DIR), $urandom, 0, 0);
      bus_xfer(1, addr_of(REGION_GPIO, GPIO_IRQ_EN), $urandom, 0, 0);
      bus_xfer(0, addr_of(REGION_GPIO, GPIO_OUT), 0, 1, 0);
      bus_xfer(0, addr_of(REGION_GPIO, GPIO_DIR), 0, 1, 0);
      bus_xfer(0, addr_of(REGION_GPIO, GPIO_IRQ_EN), 0, 1, 0);
      assert (o_gpio === m_gpio_out && o_gpio_dir === m_gpio_dir) else begin
        $display("Error: %0t ns gpio pins %h/%h differ from model", $time, o_gpio, o_gpio_dir);
        fail_stop();
      end
    end
    bus_xfer(1, addr_of(REGION_GPIO, GPIO_IRQ_EN), 0, 0, 0);

    // input sync and edge pending, bit 0 always rises
    pat = GPIO_WIDTH'($urandom) | 8'h01;
    i_gpio = pat;
    repeat (6) @(negedge i_clk);
    m_gpio_in = pat;
    m_gpio_pend = pat;
    bus_xfer(1, addr_of(REGION_GPIO, GPIO_IRQ_EN), 32'h0f, 0, 0);
    m_irq_pend[IRQ_ID_GPIO-1] = 1'b1;
    bus_xfer(0, addr_of(REGION_GPIO, GPIO_IN), 0, 1, 0);
    bus_xfer(0, addr_of(REGION_GPIO, GPIO_IRQ_PEND), 0, 1, 0);
    check_bit(o_ext_irq, 1'b0, "o_ext_irq with enables off");
    bus_xfer(1, addr_of(REGION_IRQ, IRQ_ENABLE), 32'h1, 0, 0);
    check_bit(o_ext_irq, 1'b1, "o_ext_irq with gpio enabled");
    bus_xfer(1, addr_of(REGION_IRQ, IRQ_ENABLE), 32'h0, 0, 0);
    bus_xfer(1, addr_of(REGION_GPIO, GPIO_IRQ_PEND), 32'hff, 0, 0);
    bus_xfer(0, addr_of(REGION_GPIO, GPIO_IRQ_PEND), 0, 1, 0);
    i_gpio = '0;
    m_gpio_in = '0;
    repeat (6) @(negedge i_clk);

    // timer compare
    bus_xfer(0, addr_of(REGION_TIMER, TMR_MTIME), 0, 0, 0);
    t0 = last_rdata;
    cmp = t0 + 4 + ($urandom % 16);
    bus_xfer(1, addr_of(REGION_TIMER, TMR_MTIMECMP), cmp, 0, 0);
    bus_xfer(1, addr_of(REGION_TIMER, TMR_CTRL), 32'h1, 0, 0);
    n = 0;
    while (!o_mtip) begin
      @(negedge i_clk);
      n++;
      if (n > 30 * TIMER_DIV) abort_on_timeout("o_mtip high");
    end
    m_irq_pend[IRQ_ID_TIMER-1] = 1'b1;
    bus_xfer(0, addr_of(REGION_TIMER, TMR_MTIME), 0, 0, 0);
    assert (last_rdata >= cmp) else begin
      $display("Error: %0t ns mtime %h below mtimecmp %h", $time, last_rdata, cmp);
      fail_stop();
    end
    bus_xfer(1, addr_of(REGION_TIMER, TMR_MTIMECMP), 32'hffff_ffff, 0, 0);
    bus_xfer(0, addr_of(REGION_TIMER, TMR_MTIMECMP), 0, 1, 0);
    check_bit(o_mtip, 1'b0, "o_mtip after compare reset");

    // interrupt claim order
    i_gpio = pat;
    repeat (6) @(negedge i_clk);
    m_gpio_in = pat;
    m_gpio_pend = pat;
    bus_xfer(1, addr_of(REGION_IRQ, IRQ_ENABLE), 32'h3, 0, 0);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_PENDING), 0, 1, 0);
    bus_xfer(1, addr_of(REGION_GPIO, GPIO_IRQ_PEND), 32'hff, 0, 0);
    repeat (3) @(negedge i_clk);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_CLAIM), 0, 1, 0);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_CLAIM), 0, 1, 0);
    bus_xfer(1, addr_of(REGION_TIMER, TMR_CTRL), 32'h0, 0, 0);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_CLAIM), 0, 1, 0);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_PENDING), 0, 1, 0);

    // unmapped regions answer err and leave registers alone
    bus_xfer(1, 16'h0000 | 16'(($urandom % 16) << 2), $urandom, 0, 0);
    bus_xfer(1, 16'h5004, $urandom, 0, 0);
    bus_xfer(0, 16'h0008, 0, 1, 0);
    bus_xfer(0, 16'h5000, 0, 1, 0);
    bus_xfer(0, addr_of(REGION_GPIO, GPIO_OUT), 0, 1, 0);
    bus_xfer(0, addr_of(REGION_TIMER, TMR_MTIMECMP), 0, 1, 0);
    bus_xfer(0, addr_of(REGION_IRQ, IRQ_ENABLE), 0, 1, 0);

    // master holding req after ack
    repeat (4) begin
      bus_xfer(1, addr_of(REGION_GPIO, GPIO_OUT), $urandom, 0, 1 + ($urandom % 8));
      bus_xfer(0, addr_of(REGION_GPIO, GPIO_OUT), 0, 1, 1 + ($urandom % 8));
      bus_xfer(0, addr_of(REGION_IRQ, IRQ_CLAIM), 0, 1, 1 + ($urandom % 8));
    end
    check_bit(o_gpio == m_gpio_out, 1'b1, "o_gpio against model");

    repeat (4) @(negedge i_clk);
    $display("Regression passed");
    $finish;
  end

endmodule
